/* src.f */
design/ffe_pkg.sv
design/ffe_weight_bank.sv
design/ffe_code_history.sv
design/ffe_mac_array.sv
design/ffe_result_scaler.sv
design/ffe_top.sv
dv/ffe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FFE testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module ffe_tb -f src.f -o ffe_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

sim_out=$(./obj_dir/ffe_sim)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
   exit 0
fi

echo "pass message not found"
exit 1

/* dv/ffe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_tb
   import ffe_pkg::*;
();

   localparam int lanes  = lane_count_dflt;
   localparam int taps   = tap_count_dflt;
   localparam int res_hi = 2 ** (result_w - 1) - 1;
   localparam int res_lo = -(2 ** (result_w - 1));

   typedef enum logic [2:0] {
      s_idle, s_write, s_commit, s_block, s_write_commit, s_commit_block
   } kind_e;
   typedef enum logic [2:0] {p_zero, p_impulse, p_random, p_max, p_min} pat_e;

   typedef struct packed {
      logic [3:0] test;
      kind_e      kind;
      tap_addr_t  addr;
      weight_t    data;
      shift_t     shift;
      pat_e       pat;
      logic [2:0] pos;                          // impulse lane
   } step_t;

   typedef result_t [lanes-1:0] res_blk_t;

   logic                clk;
   logic                rst_n;
   code_t [lanes-1:0]   codes;
   logic                code_valid;
   logic                weight_wr;
   tap_addr_t           weight_addr;
   weight_t             weight_data;
   shift_t              shift_data;
   logic                weight_commit;
   result_t [lanes-1:0] results;
   logic                result_valid;

   step_t    steps [$];
   res_blk_t exp_q [$];
   int       exp_test_q [$];
   int       serial [$];                        // every valid sample so far
   int       shadow_w [taps];
   int       active_w [taps];
   int       active_sh;
   int       test_checks [8];
   int       test_errs [8];
   int       cur_test;
   int       cycles;
   int       limit;

   ffe_top #(
      .lane_count    (lanes),
      .tap_count     (taps)
   ) dut0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .codes         (codes),
      .code_valid    (code_valid),
      .weight_wr     (weight_wr),
      .weight_addr   (weight_addr),
      .weight_data   (weight_data),
      .shift_data    (shift_data),
      .weight_commit (weight_commit),
      .results       (results),
      .result_valid  (result_valid)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic int scale_sum(input longint acc, input int sh);
      longint v;
      v = acc;
      if (sh > 0) begin
         v = v + (longint'(1) << (sh - 1));     // round half up
      end
      v = v >>> sh;
      if (v > res_hi) begin
         v = res_hi;
      end else if (v < res_lo) begin
         v = res_lo;
      end
      return int'(v);
   endfunction

   task automatic model_block(input code_t [lanes-1:0] blk, input int t);
      res_blk_t exp_blk;
      longint   acc;
      int       base;
      int       idx;
      base = serial.size();
      for (int j = 0; j < lanes; j++) begin
         serial.push_back(int'(blk[j]));
      end
      for (int j = 0; j < lanes; j++) begin
         acc = 0;
         idx = base + j;
         for (int k = 0; k < taps; k++) begin
            if (idx - k >= 0) begin
               acc = acc + longint'(active_w[k]) * longint'(serial[idx-k]);
            end
         end
         exp_blk[j] = result_t'(scale_sum(acc, active_sh));
      end
      exp_q.push_back(exp_blk);
      exp_test_q.push_back(t);
   endtask

   task automatic check_val(input string name, input int got, input int exp_v, input int t);
      test_checks[t]++;
      assert (got == exp_v) else begin
         $display("Error: time %0t %s expected %0d got %0d", $time, name, exp_v, got);
         test_errs[t]++;
      end
   endtask

   ////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////
   task automatic add_step(input int t, input kind_e kind, input int addr, input int data,
                           input int sh, input pat_e pat, input int pos);
      step_t s;
      s.test  = 4'(t);
      s.kind  = kind;
      s.addr  = tap_addr_t'(addr);
      s.data  = weight_t'(data);
      s.shift = shift_t'(sh);
      s.pat   = pat;
      s.pos   = 3'(pos);
      steps.push_back(s);
   endtask

   task automatic add_idle(input int t, input int n);
      repeat (n) add_step(t, s_idle, 0, 0, 0, p_zero, 0);
   endtask

   function automatic int rand_weight();
      return int'($urandom_range(255)) - 128;
   endfunction

   task automatic build_table();
      int imp_w [taps];
      imp_w = '{100, -50, 25, -12, 6, -3, 2, -1, 200, -300};
      add_idle(1, 6);
      // impulse at lane 5, taps spill into the next block
      for (int k = 0; k < taps; k++) add_step(2, s_write, k, imp_w[k], 0, p_zero, 0);
      add_step(2, s_commit, 0, 0, 0, p_zero, 0);
      add_step(2, s_block, 0, 0, 0, p_impulse, 5);
      add_step(2, s_block, 0, 0, 0, p_zero, 0);
      add_step(2, s_block, 0, 0, 0, p_zero, 0);
      add_idle(2, 5);
      for (int k = 0; k < taps; k++) add_step(3, s_write, k, rand_weight(), 0, p_zero, 0);
      add_step(3, s_commit, 0, 0, 6, p_zero, 0);
      repeat (12) add_step(3, s_block, 0, 0, 0, p_random, 0);
      add_idle(3, 5);
      // shadow writes between blocks, then commit with and without a block
      for (int k = 0; k < taps; k++) begin
         add_step(4, s_write, k, rand_weight(), 0, p_zero, 0);
         add_step(4, s_block, 0, 0, 0, p_random, 0);
      end
      add_step(4, s_commit_block, 0, 0, 5, p_random, 0);
      add_step(4, s_block, 0, 0, 0, p_random, 0);
      add_step(4, s_write_commit, 0, rand_weight(), 2, p_zero, 0);
      repeat (3) add_step(4, s_block, 0, 0, 0, p_random, 0);
      add_idle(4, 5);
      for (int k = 0; k < taps; k++) add_step(5, s_write, k, 511, 0, p_zero, 0);
      add_step(5, s_commit, 0, 0, 0, p_zero, 0);
      add_step(5, s_block, 0, 0, 0, p_max, 0);
      add_step(5, s_block, 0, 0, 0, p_min, 0);
      for (int k = 0; k < taps; k++) add_step(5, s_write, k, (k == 0) ? 1 : 0, 0, p_zero, 0);
      add_step(5, s_commit_block, 0, 0, 1, p_random, 0);
      repeat (5) add_step(5, s_block, 0, 0, 0, p_random, 0);
      add_step(5, s_commit_block, 0, 0, 15, p_max, 0);
      add_idle(5, 5);
      for (int k = 0; k < taps; k++) add_step(6, s_write, k, rand_weight(), 0, p_zero, 0);
      add_step(6, s_commit, 0, 0, 4, p_zero, 0);
      add_step(6, s_block, 0, 0, 0, p_random, 0);
      add_idle(6, 2);
      add_step(6, s_block, 0, 0, 0, p_random, 0);
      add_idle(6, 3);
      repeat (2) add_step(6, s_block, 0, 0, 0, p_random, 0);
      add_idle(6, 5);
   endtask

   function automatic string test_name(input int t);
      case (t)
         1:       return "reset idle";
         2:       return "impulse";
         3:       return "random blocks";
         4:       return "commit timing";
         5:       return "shift and saturation";
         6:       return "valid gaps";
         default: return "unknown";
      endcase
   endfunction

   ////////////////////////////////////////
   // driver
   ////////////////////////////////////////
   task automatic apply_step(input step_t s);
      code_t [lanes-1:0] blk;
      logic              wr;
      logic              cm;
      logic              vl;
      blk = '0;
      case (s.pat)
         p_impulse: blk[s.pos] = 8'sd1;
         p_random:  for (int j = 0; j < lanes; j++) blk[j] = code_t'($urandom);
         p_max:     for (int j = 0; j < lanes; j++) blk[j] = 8'sd127;
         p_min:     for (int j = 0; j < lanes; j++) blk[j] = -8'sd128;
         default:   blk = '0;
      endcase
      wr = (s.kind == s_write) || (s.kind == s_write_commit);
      cm = (s.kind == s_commit) || (s.kind == s_write_commit) || (s.kind == s_commit_block);
      vl = (s.kind == s_block) || (s.kind == s_commit_block);
      @(posedge clk);
      weight_wr     <= wr;
      weight_commit <= cm;
      code_valid    <= vl;
      weight_addr   <= s.addr;
      weight_data   <= s.data;
      shift_data    <= s.shift;
      codes         <= blk;
      if (cm) begin                             // commit sees the shadow before this write
         active_w  = shadow_w;
         active_sh = int'(s.shift);
      end
      if (wr) begin
         shadow_w[s.addr] = int'($signed(s.data));
      end
      if (vl) begin
         model_block(blk, int'(s.test));
      end
      if (s.test == 4'd1) begin
         check_val("result_valid", int'(result_valid), 0, 1);
         for (int j = 0; j < lanes; j++) begin
            check_val($sformatf("results[%0d]", j), int'(results[j]), 0, 1);
         end
      end
   endtask

   task automatic finish_test(input int t);
      while (exp_q.size() != 0) @(posedge clk);
      @(posedge clk);
      $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), test_checks[t],
               test_errs[t]);
   endtask

   // compare each result block against the model
   initial begin
      res_blk_t exp_blk;
      int       t;
      wait (rst_n === 1'b1);
      forever begin
         @(posedge clk);
         if (result_valid) begin
            assert (exp_q.size() != 0) else begin
               $display("Unexpected result_valid at time %0t with no block in flight", $time);
               test_errs[cur_test]++;
            end
            if (exp_q.size() != 0) begin
               exp_blk = exp_q.pop_front();
               t = exp_test_q.pop_front();
               for (int j = 0; j < lanes; j++) begin
                  check_val($sformatf("results[%0d]", j), int'(results[j]), int'(exp_blk[j]), t);
               end
            end
         end
      end
   end

   initial begin
      wait (rst_n === 1'b1);
      limit = 2 * steps.size() + 50;            // budget grows with the table
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int total_chk;
      int total_err;
      int prev_test;
      void'($urandom(32'h9ac97a21));
      rst_n         = 1'b0;
      codes         = '0;
      code_valid    = 1'b0;
      weight_wr     = 1'b0;
      weight_addr   = '0;
      weight_data   = '0;
      shift_data    = '0;
      weight_commit = 1'b0;
      active_sh     = 0;
      build_table();
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      prev_test = int'(steps[0].test);
      cur_test  = prev_test;
      foreach (steps[i]) begin
         if (int'(steps[i].test) != prev_test) begin
            finish_test(prev_test);
            prev_test = int'(steps[i].test);
            cur_test  = prev_test;
         end
         apply_step(steps[i]);
      end
      finish_test(prev_test);
      total_chk = 0;
      total_err = 0;
      for (int t = 0; t < 8; t++) begin
         total_chk += test_checks[t];
         total_err += test_errs[t];
      end
      $display("total: %0d checks, %0d errors", total_chk, total_err);
      if (total_err == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* design/ffe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_top
   import ffe_pkg::*;
#(
   parameter int lane_count = lane_count_dflt,
   parameter int tap_count  = tap_count_dflt
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  code_t [lane_count-1:0]   codes,
   input  logic                     code_valid,
   input  logic                     weight_wr,
   input  tap_addr_t                weight_addr,
   input  weight_t                  weight_data,
   input  shift_t                   shift_data,
   input  logic                     weight_commit,
   output result_t [lane_count-1:0] results,
   output logic                     result_valid
);

   weight_t [tap_count-1:0]               active_weights;
   shift_t                                active_shift;
   code_t [lane_count-1:0][tap_count-1:0] windows;
   logic                                  window_valid;
   acc_t [lane_count-1:0]                 lane_sums;
   logic                                  sums_valid;
   shift_t                                sums_shift;

   ffe_weight_bank #(
      .tap_count      (tap_count)
   ) u_bank (
      .clk            (clk),
      .rst_n          (rst_n),
      .weight_wr      (weight_wr),
      .weight_addr    (weight_addr),
      .weight_data    (weight_data),
      .shift_data     (shift_data),
      .weight_commit  (weight_commit),
      .active_weights (active_weights),
      .active_shift   (active_shift)
   );

   ffe_code_history #(
      .lane_count     (lane_count),
      .tap_count      (tap_count)
   ) u_hist (
      .clk            (clk),
      .rst_n          (rst_n),
      .codes          (codes),
      .code_valid     (code_valid),
      .windows        (windows),
      .window_valid   (window_valid)
   );

   ffe_mac_array #(
      .lane_count     (lane_count),
      .tap_count      (tap_count)
   ) u_mac (
      .clk            (clk),
      .rst_n          (rst_n),
      .windows        (windows),
      .window_valid   (window_valid),
      .active_weights (active_weights),
      .active_shift   (active_shift),
      .lane_sums      (lane_sums),
      .sums_valid     (sums_valid),
      .sums_shift     (sums_shift)
   );

   ffe_result_scaler #(
      .lane_count     (lane_count)
   ) u_scale (
      .clk            (clk),
      .rst_n          (rst_n),
      .lane_sums      (lane_sums),
      .sums_valid     (sums_valid),
      .sums_shift     (sums_shift),
      .results        (results),
      .result_valid   (result_valid)
   );

endmodule

`default_nettype wire

/* design/ffe_result_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_result_scaler
   import ffe_pkg::*;
#(
   parameter int lane_count = lane_count_dflt
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  acc_t [lane_count-1:0]    lane_sums,
   input  logic                     sums_valid,
   input  shift_t                   sums_shift,
   output result_t [lane_count-1:0] results,
   output logic                     result_valid
);

   localparam int res_max = 2 ** (result_w - 1) - 1;
   localparam int res_min = -(2 ** (result_w - 1));

   typedef logic signed [acc_w:0] wide_t;      // one bit of room for the offset

   wide_t   round_ofs;
   wide_t   shifted [lane_count];
   result_t clamped [lane_count];

   assign round_ofs = (sums_shift == '0) ? '0 : (wide_t'(1) << (sums_shift - 1'b1));

   always_comb begin
      for (int j = 0; j < lane_count; j++) begin
         shifted[j] = (wide_t'(acc_t'(lane_sums[j])) + round_ofs) >>> sums_shift;
         if (shifted[j] > res_max) begin
            clamped[j] = result_t'(res_max);
         end else if (shifted[j] < res_min) begin
            clamped[j] = result_t'(res_min);
         end else begin
            clamped[j] = result_t'(shifted[j]);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         results      <= '0;
         result_valid <= 1'b0;
      end else begin
         result_valid <= sums_valid;
         if (sums_valid) begin
            for (int j = 0; j < lane_count; j++) begin
               results[j] <= clamped[j];
            end
         end
      end
   end

   // limit values only appear when the unclamped value reached them
   for (genvar j = 0; j < lane_count; j++) begin : g_sat_chk
      a_sat_hi : assert property (
         @(posedge clk) disable iff (!rst_n)
         result_valid && (results[j] == result_t'(res_max)) |-> $past(shifted[j]) >= res_max
      );
      a_sat_lo : assert property (
         @(posedge clk) disable iff (!rst_n)
         result_valid && (results[j] == result_t'(res_min)) |-> $past(shifted[j]) <= res_min
      );
   end

endmodule

`default_nettype wire

/* design/ffe_mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_mac_array
   import ffe_pkg::*;
#(
   parameter int lane_count = lane_count_dflt,
   parameter int tap_count  = tap_count_dflt
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  code_t [lane_count-1:0][tap_count-1:0]  windows,
   input  logic                                   window_valid,
   input  weight_t [tap_count-1:0]                active_weights,
   input  shift_t                                 active_shift,
   output acc_t [lane_count-1:0]                  lane_sums,
   output logic                                   sums_valid,
   output shift_t                                 sums_shift
);

   // leaves padded up to a power of two
   localparam int tree_n = 1 << $clog2(tap_count);

   product_t prod [lane_count][tap_count];
   logic     p_valid;
   shift_t   p_shift;

   acc_t     node [lane_count][2*tree_n-1];     // heap order, [0] is the root

   ////////////////////////////////////////
   // stage one: products
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int j = 0; j < lane_count; j++) begin
            for (int k = 0; k < tap_count; k++) begin
               prod[j][k] <= '0;
            end
         end
         p_valid <= 1'b0;
         p_shift <= '0;
      end else begin
         for (int j = 0; j < lane_count; j++) begin
            for (int k = 0; k < tap_count; k++) begin
               prod[j][k] <= code_t'(windows[j][k]) * weight_t'(active_weights[k]);
            end
         end
         p_valid <= window_valid;
         p_shift <= active_shift;               // block carries its own shift
      end
   end

   ////////////////////////////////////////
   // adder tree
   ////////////////////////////////////////
   always_comb begin
      for (int j = 0; j < lane_count; j++) begin
         for (int i = 0; i < tap_count; i++) begin
            node[j][tree_n-1+i] = acc_t'(prod[j][i]);   // sign extended leaf
         end
         for (int i = tap_count; i < tree_n; i++) begin
            node[j][tree_n-1+i] = '0;
         end
         for (int i = tree_n - 2; i >= 0; i--) begin
            node[j][i] = node[j][2*i+1] + node[j][2*i+2];
         end
      end
   end

   ////////////////////////////////////////
   // stage two: lane sums
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lane_sums  <= '0;
         sums_valid <= 1'b0;
         sums_shift <= '0;
      end else begin
         for (int j = 0; j < lane_count; j++) begin
            lane_sums[j] <= node[j][0];
         end
         sums_valid <= p_valid;
         sums_shift <= p_shift;
      end
   end

endmodule

`default_nettype wire

/* design/ffe_code_history.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_code_history
   import ffe_pkg::*;
#(
   parameter int lane_count = lane_count_dflt,
   parameter int tap_count  = tap_count_dflt
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  code_t [lane_count-1:0]                 codes,
   input  logic                                   code_valid,
   output code_t [lane_count-1:0][tap_count-1:0]  windows,
   output logic                                   window_valid
);

   // earlier blocks needed to reach tap_count-1 samples back
   localparam int hist_blocks = (tap_count + lane_count - 2) / lane_count;

   code_t [hist_blocks:0][lane_count-1:0] blocks;   // [0] newest block

   if (tap_count < 1) begin : g_bad_taps
      $error("ffe_code_history needs tap_count of at least 1");
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         blocks       <= '0;
         window_valid <= 1'b0;
      end else begin
         window_valid <= code_valid;
         if (code_valid) begin                     // stream only advances on valid
            for (int i = hist_blocks; i > 0; i--) begin
               blocks[i] <= blocks[i-1];
            end
            blocks[0] <= codes;
         end
      end
   end

   ////////////////////////////////////////
   // window slicing
   ////////////////////////////////////////
   // tap k of lane j is serial offset j-k from the start of the newest block,
   // negative offsets fall into the older blocks
   for (genvar j = 0; j < lane_count; j++) begin : g_lane
      for (genvar k = 0; k < tap_count; k++) begin : g_tap
         localparam int ofs = j - k;
         localparam int blk = (ofs >= 0) ? 0 : (lane_count - 1 - ofs) / lane_count;
         localparam int pos = ofs + blk * lane_count;
         assign windows[j][k] = blocks[blk][pos];
      end
   end

endmodule

`default_nettype wire

/* design/ffe_weight_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_weight_bank
   import ffe_pkg::*;
#(
   parameter int tap_count = tap_count_dflt
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    weight_wr,
   input  tap_addr_t               weight_addr,
   input  weight_t                 weight_data,
   input  shift_t                  shift_data,
   input  logic                    weight_commit,
   output weight_t [tap_count-1:0] active_weights,
   output shift_t                  active_shift
);

   weight_t [tap_count-1:0] shadow_weights;   // staged by the write port
   logic                    addr_ok;

   assign addr_ok = (weight_addr < tap_count);

   ////////////////////////////////////////
   // shadow bank
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         shadow_weights <= '0;
      end else if (weight_wr && addr_ok) begin
         shadow_weights[weight_addr] <= weight_data;
      end
   end

   ////////////////////////////////////////
   // active set
   ////////////////////////////////////////
   // a write on the commit edge lands in the shadow only, the active set
   // picks up the shadow contents from before that edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active_weights <= '0;
         active_shift   <= '0;
      end else if (weight_commit) begin
         active_weights <= shadow_weights;
         active_shift   <= shift_data;          // shift taken straight from the port
      end
   end

   // taps outside the bank are never addressed
   a_addr_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      weight_wr |-> addr_ok
   );

endmodule

`default_nettype wire

/* design/ffe_pkg.sv */
`default_nettype none

package ffe_pkg;

   ////////////////////////////////////////
   // array geometry
   ////////////////////////////////////////
   localparam int lane_count_dflt = 8;     // samples per block
   localparam int tap_count_dflt  = 10;    // fir length

   ////////////////////////////////////////
   // datapath widths
   ////////////////////////////////////////
   localparam int code_w    = 8;
   localparam int weight_w  = 10;
   localparam int product_w = code_w + weight_w;
   localparam int guard_w   = 4;           // covers up to 16 taps
   localparam int acc_w     = product_w + guard_w;
   localparam int result_w  = 10;
   localparam int shift_w   = 4;
   localparam int tap_addr_w = 4;

   typedef logic signed [code_w-1:0]    code_t;
   typedef logic signed [weight_w-1:0]  weight_t;
   typedef logic signed [product_w-1:0] product_t;
   typedef logic signed [acc_w-1:0]     acc_t;
   typedef logic signed [result_w-1:0]  result_t;
   typedef logic [shift_w-1:0]          shift_t;
   typedef logic [tap_addr_w-1:0]       tap_addr_t;

endpackage

`default_nettype wire
